//--- Makefile
TOP = dcx_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

//--- logic/dcx_config.svh
`ifndef DCX_CONFIG_SVH
`define DCX_CONFIG_SVH

// ##########################################################
// active picture, kept small so a frame simulates quickly
// ##########################################################
`define DCX_FRAME_WIDTH 8
`define DCX_FRAME_HEIGHT 4

// buffer holds exactly one frame of pixels
`define DCX_RAM_ADDRESS_BITS 5

// ##########################################################
// output raster, blanking wraps the active area
// ##########################################################
`define DCX_H_TOTAL 12
`define DCX_H_SYNC 2            // sync sits in the last columns of a line
`define DCX_V_TOTAL 6
`define DCX_V_SYNC 1            // and in the last lines of a frame

`define DCX_STARTUP_CYCLES 16   // hdmi_clock cycles before the output runs

`endif

//--- logic/dcx_pkg.sv
package dcx_pkg;

`include "dcx_config.svh"

    // red in the top byte, then green, then blue
    typedef logic [23:0] pixel_t;

    // raster counters on both sides of the buffer
    typedef logic [11:0] coord_t;

    typedef logic [`DCX_RAM_ADDRESS_BITS-1:0] addr_t;

endpackage

//--- logic/dcx_top.sv
`timescale 1ns/1ps

module dcx_top (
    input  logic        clock54,
    input  logic        hdmi_clock,
    input  logic        arst_n,
    input  logic        _hsync,
    input  logic        _vsync,
    input  logic [11:0] data,
    output logic        HSYNC,
    output logic        VSYNC,
    output logic        DE,
    output logic [23:0] VIDEO
);

    dcx_pkg::pixel_t dc_pixel;
    logic            dc_pixel_valid;
    dcx_pkg::coord_t data_in_counter_x;
    dcx_pkg::coord_t data_in_counter_y;

    logic            ram_wren;
    dcx_pkg::addr_t  ram_wraddress;
    dcx_pkg::pixel_t ram_wrdata;
    dcx_pkg::addr_t  ram_rdaddress;
    dcx_pkg::pixel_t ram_rddata;

    logic            buffer_ready_trigger;
    logic            output_trigger;
    logic            output_ready;

    // ##########################################################
    // console side, clock54
    // ##########################################################
    video_capture video_input (
        .clock54     (clock54),
        .arst_n      (arst_n),
        ._hsync      (_hsync),
        ._vsync      (_vsync),
        .data        (data),
        .pixel       (dc_pixel),
        .pixel_valid (dc_pixel_valid),
        .x           (data_in_counter_x),
        .y           (data_in_counter_y)
    );

    frame_writer video2ram (
        .clock54     (clock54),
        .arst_n      (arst_n),
        .pixel       (dc_pixel),
        .pixel_valid (dc_pixel_valid),
        .x           (data_in_counter_x),
        .y           (data_in_counter_y),
        .wren        (ram_wren),
        .wraddress   (ram_wraddress),
        .wrdata      (ram_wrdata),
        .frame_done  (buffer_ready_trigger)
    );

    // ##########################################################
    // crossing into hdmi_clock
    // ##########################################################
    frame_buffer video_buffer (
        .wrclock   (clock54),
        .wren      (ram_wren),
        .wraddress (ram_wraddress),
        .data      (ram_wrdata),
        .rdclock   (hdmi_clock),
        .rdaddress (ram_rdaddress),
        .q         (ram_rddata)
    );

    flag_cross_domain trigger (
        .clock_a (clock54),
        .clock_b (hdmi_clock),
        .arst_n  (arst_n),
        .flag_a  (buffer_ready_trigger),
        .flag_b  (output_trigger)
    );

    startup_delay ram2video_startup_delay (
        .hdmi_clock (hdmi_clock),
        .arst_n     (arst_n),
        .ready      (output_ready)
    );

    raster_reader ram2video (
        .hdmi_clock  (hdmi_clock),
        .arst_n      (arst_n),
        .ready       (output_ready),
        .frame_start (output_trigger),
        .rddata      (ram_rddata),
        .rdaddress   (ram_rdaddress),
        .hsync       (HSYNC),
        .vsync       (VSYNC),
        .de          (DE),
        .video       (VIDEO)
    );

endmodule

//--- logic/flag_cross_domain.sv
`timescale 1ns/1ps

module flag_cross_domain (
    input  logic clock_a,
    input  logic clock_b,
    input  logic arst_n,
    input  logic flag_a,
    output logic flag_b
);

    logic       toggle_a;
    logic [2:0] sync_b;

    always_ff @(posedge clock_a or negedge arst_n) begin
        if (!arst_n) begin
            toggle_a <= 1'b0;
        end else begin
            toggle_a <= toggle_a ^ flag_a;   // each pulse becomes a level change
        end
    end

    always_ff @(posedge clock_b or negedge arst_n) begin
        if (!arst_n) begin
            sync_b <= '0;
        end else begin
            sync_b <= {sync_b[1:0], toggle_a};
        end
    end

    // any change of the synchronized level is one pulse in domain b
    assign flag_b = sync_b[2] ^ sync_b[1];

    single_cycle_flag: assert property (@(posedge clock_a) disable iff (!arst_n)
        flag_a |=> !flag_a);

endmodule

//--- logic/frame_buffer.sv
`timescale 1ns/1ps

`include "dcx_config.svh"

module frame_buffer (
    input  logic             wrclock,
    input  logic             wren,
    input  dcx_pkg::addr_t   wraddress,
    input  dcx_pkg::pixel_t  data,
    input  logic             rdclock,
    input  dcx_pkg::addr_t   rdaddress,
    output dcx_pkg::pixel_t  q
);

    dcx_pkg::pixel_t mem [0:(1 << `DCX_RAM_ADDRESS_BITS) - 1];

    // write port lives in the console domain
    always_ff @(posedge wrclock) begin
        if (wren) begin
            mem[wraddress] <= data;
        end
    end

    always_ff @(posedge rdclock) begin
        q <= mem[rdaddress];   // one cycle read latency
    end

endmodule

//--- logic/frame_writer.sv
`timescale 1ns/1ps

`include "dcx_config.svh"

module frame_writer (
    input  logic             clock54,
    input  logic             arst_n,
    input  dcx_pkg::pixel_t  pixel,
    input  logic             pixel_valid,
    input  dcx_pkg::coord_t  x,
    input  dcx_pkg::coord_t  y,
    output logic             wren,
    output dcx_pkg::addr_t   wraddress,
    output dcx_pkg::pixel_t  wrdata,
    output logic             frame_done
);

    logic            in_frame;
    logic            last_pixel;
    dcx_pkg::coord_t linear;

    assign in_frame   = (x < dcx_pkg::coord_t'(`DCX_FRAME_WIDTH)) &&
                        (y < dcx_pkg::coord_t'(`DCX_FRAME_HEIGHT));
    assign last_pixel = (x == dcx_pkg::coord_t'(`DCX_FRAME_WIDTH - 1)) &&
                        (y == dcx_pkg::coord_t'(`DCX_FRAME_HEIGHT - 1));
    assign linear     = y * dcx_pkg::coord_t'(`DCX_FRAME_WIDTH) + x;   // row major

    always_ff @(posedge clock54 or negedge arst_n) begin
        if (!arst_n) begin
            wren       <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            wren       <= pixel_valid && in_frame;
            frame_done <= pixel_valid && last_pixel;   // same cycle as the final write
        end
    end

    always_ff @(posedge clock54) begin
        if (pixel_valid) begin
            wraddress <= linear[`DCX_RAM_ADDRESS_BITS-1:0];
            wrdata    <= pixel;
        end
    end

    // pixels outside the window must never alias into the frame
    wraddress_in_frame: assert property (@(posedge clock54) disable iff (!arst_n)
        wren |-> (32'($past(linear)) < `DCX_FRAME_WIDTH * `DCX_FRAME_HEIGHT));

endmodule

//--- logic/raster_reader.sv
`timescale 1ns/1ps

`include "dcx_config.svh"

module raster_reader (
    input  logic             hdmi_clock,
    input  logic             arst_n,
    input  logic             ready,
    input  logic             frame_start,
    input  dcx_pkg::pixel_t  rddata,
    output dcx_pkg::addr_t   rdaddress,
    output logic             hsync,
    output logic             vsync,
    output logic             de,
    output logic [23:0]      video
);

    logic            running;
    logic            last_pos;
    logic            issue;        // a column goes out to the buffer this cycle
    logic            active_1;
    logic            hsync_1;
    logic            vsync_1;
    dcx_pkg::coord_t col;
    dcx_pkg::coord_t line;
    dcx_pkg::coord_t next_col;
    dcx_pkg::coord_t next_line;
    dcx_pkg::coord_t issue_col;
    dcx_pkg::coord_t issue_line;
    dcx_pkg::coord_t issue_linear;

    // ##########################################################
    // position of the column issued this cycle
    // ##########################################################
    always_comb begin
        next_col  = col + 12'd1;
        next_line = line;
        if (col == dcx_pkg::coord_t'(`DCX_H_TOTAL - 1)) begin
            next_col  = '0;
            next_line = line + 12'd1;
        end
    end

    assign last_pos = (col == dcx_pkg::coord_t'(`DCX_H_TOTAL - 1)) &&
                      (line == dcx_pkg::coord_t'(`DCX_V_TOTAL - 1));

    // starts are ignored while a frame runs or before ready
    assign issue      = running ? !last_pos : (ready && frame_start);
    assign issue_col  = running ? next_col : '0;
    assign issue_line = running ? next_line : '0;

    assign issue_linear = issue_line * dcx_pkg::coord_t'(`DCX_FRAME_WIDTH) + issue_col;

    // ##########################################################
    // stage 1 follows the read, stage 2 lines up with q
    // ##########################################################
    always_ff @(posedge hdmi_clock or negedge arst_n) begin
        if (!arst_n) begin
            running  <= 1'b0;
            col      <= '0;
            line     <= '0;
            active_1 <= 1'b0;
            hsync_1  <= 1'b1;
            vsync_1  <= 1'b1;
            de       <= 1'b0;
            hsync    <= 1'b1;
            vsync    <= 1'b1;
        end else begin
            running <= issue;   // drops after the last column of the frame
            if (issue) begin
                col  <= issue_col;
                line <= issue_line;
            end
            active_1 <= issue &&
                        (issue_col < dcx_pkg::coord_t'(`DCX_FRAME_WIDTH)) &&
                        (issue_line < dcx_pkg::coord_t'(`DCX_FRAME_HEIGHT));
            hsync_1  <= !(issue &&
                          (issue_col >= dcx_pkg::coord_t'(`DCX_H_TOTAL - `DCX_H_SYNC)));
            vsync_1  <= !(issue &&
                          (issue_line >= dcx_pkg::coord_t'(`DCX_V_TOTAL - `DCX_V_SYNC)));
            de       <= active_1;
            hsync    <= hsync_1;
            vsync    <= vsync_1;
        end
    end

    always_ff @(posedge hdmi_clock) begin
        rdaddress <= issue_linear[`DCX_RAM_ADDRESS_BITS-1:0];
    end

    assign video = de ? rddata : 24'd0;   // blanking is black

    // sync regions lie outside the active window of the raster
    de_outside_sync: assert property (@(posedge hdmi_clock) disable iff (!arst_n)
        de |-> (hsync && vsync));

endmodule

//--- logic/startup_delay.sv
`timescale 1ns/1ps

`include "dcx_config.svh"

module startup_delay (
    input  logic hdmi_clock,
    input  logic arst_n,
    output logic ready
);

    int unsigned count;

    always_ff @(posedge hdmi_clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= 0;
            ready <= 1'b0;
        end else if (!ready) begin   // counter freezes once ready is up
            count <= count + 1;
            if (count == `DCX_STARTUP_CYCLES - 1) begin
                ready <= 1'b1;
            end
        end
    end

endmodule

//--- logic/video_capture.sv
`timescale 1ns/1ps

module video_capture (
    input  logic             clock54,
    input  logic             arst_n,
    input  logic             _hsync,
    input  logic             _vsync,
    input  logic [11:0]      data,
    output dcx_pkg::pixel_t  pixel,
    output logic             pixel_valid,
    output dcx_pkg::coord_t  x,
    output dcx_pkg::coord_t  y
);

    logic            hsync_q;
    logic            vsync_q;
    logic            phase;        // high when the next bus word is word B
    logic            new_frame;
    logic            line_start;
    logic            frame_edge;
    logic [11:0]     word_a;
    dcx_pkg::coord_t col_count;
    dcx_pkg::coord_t line_count;

    assign line_start = _hsync & ~hsync_q;   // rising edge of the active-low hsync
    assign frame_edge = vsync_q & ~_vsync;

    // ##########################################################
    // sync edges, word phase and raster counters
    // ##########################################################
    always_ff @(posedge clock54 or negedge arst_n) begin
        if (!arst_n) begin
            hsync_q     <= 1'b1;
            vsync_q     <= 1'b1;
            phase       <= 1'b0;
            new_frame   <= 1'b0;
            col_count   <= '0;
            line_count  <= '0;
            pixel_valid <= 1'b0;
            x           <= '0;
            y           <= '0;
        end else begin
            hsync_q     <= _hsync;
            vsync_q     <= _vsync;
            pixel_valid <= 1'b0;
            if (frame_edge) begin
                new_frame <= 1'b1;   // line count restarts at the next line
            end
            if (line_start) begin
                phase     <= 1'b1;   // this cycle carries word A
                col_count <= '0;
                if (new_frame || frame_edge) begin
                    line_count <= '0;
                    new_frame  <= 1'b0;
                end else begin
                    line_count <= line_count + 12'd1;
                end
            end else if (!_hsync) begin
                phase <= 1'b0;
            end else if (phase) begin
                phase       <= 1'b0;
                pixel_valid <= 1'b1;
                x           <= col_count;
                y           <= line_count;
                col_count   <= col_count + 12'd1;
            end else begin
                phase <= 1'b1;
            end
        end
    end

    // word A gives red and the high green nibble, word B the rest
    always_ff @(posedge clock54) begin
        if (_hsync) begin
            if (phase) begin
                pixel <= {word_a, data};
            end else begin
                word_a <= data;
            end
        end
    end

endmodule

//--- sources.f
+incdir+logic
logic/dcx_pkg.sv
logic/video_capture.sv
logic/frame_writer.sv
logic/frame_buffer.sv
logic/flag_cross_domain.sv
logic/startup_delay.sv
logic/raster_reader.sv
logic/dcx_top.sv
test/dcx_tb.sv

//--- test/dcx_tb.sv
`timescale 1ns/1ps

`include "dcx_config.svh"

module dcx_tb;

    localparam int PATTERN_COUNT       = 64;
    localparam int FRAME_PIXELS        = `DCX_FRAME_WIDTH * `DCX_FRAME_HEIGHT;
    localparam int FRAME_COUNT         = PATTERN_COUNT / FRAME_PIXELS;
    localparam int VSYNC_PULSE         = 2;
    localparam int HSYNC_LOW           = 4;
    localparam int LINE_BLANK          = 6;
    localparam int INPUT_FRAME_CYCLES  = VSYNC_PULSE + `DCX_FRAME_HEIGHT *
                                         (HSYNC_LOW + 2 * `DCX_FRAME_WIDTH + LINE_BLANK);
    localparam int OUTPUT_FRAME_CYCLES = `DCX_V_TOTAL * `DCX_H_TOTAL;
    localparam int TIMEOUT_MARGIN      = 2;
    localparam int TIMEOUT_CYCLES      = TIMEOUT_MARGIN * (`DCX_STARTUP_CYCLES +
                                         FRAME_COUNT * (INPUT_FRAME_CYCLES + OUTPUT_FRAME_CYCLES));

    logic        clock54 = 1'b0;
    logic        hdmi_clock = 1'b0;
    logic        arst_n;
    logic        _hsync;
    logic        _vsync;
    logic [11:0] data;
    logic        hsync;
    logic        vsync;
    logic        de;
    logic [23:0] video;

    logic [23:0] patterns [0:PATTERN_COUNT-1];
    logic [23:0] captured [0:PATTERN_COUNT-1];   // output pixels in raster order
    int          error_count = 0;
    int          errors_at_mark = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    int          frames_done = 0;
    int          position;
    int          de_cycles;
    int          hsync_low_cycles;
    int          vsync_low_cycles;
    logic        in_frame = 1'b0;

    dcx_top UUT (
        .clock54    (clock54),
        .hdmi_clock (hdmi_clock),
        .arst_n     (arst_n),
        ._hsync     (_hsync),
        ._vsync     (_vsync),
        .data       (data),
        .HSYNC      (hsync),
        .VSYNC      (vsync),
        .DE         (de),
        .VIDEO      (video)
    );

    always #2 clock54 = ~clock54;

    // output clock runs 1 ns behind the console clock
    always begin
        #1;
        forever #2 hdmi_clock = ~hdmi_clock;
    end

    // word A carries red and the high green nibble, word B the low nibble and blue
    function automatic logic [11:0] first_word(input logic [23:0] p);
        return {p[23:16], p[15:12]};
    endfunction

    function automatic logic [11:0] second_word(input logic [23:0] p);
        return {p[11:8], p[7:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, got %h at %0t", name, expected, actual, $time);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name);
        if (error_count == errors_at_mark) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", name, error_count - errors_at_mark);
        end
        errors_at_mark = error_count;
    endtask

    task automatic drive_bus(input logic hsync_level, input logic vsync_level,
                             input logic [11:0] word);
        @(posedge clock54);
        #1;
        _hsync = hsync_level;
        _vsync = vsync_level;
        data   = word;
    endtask

    // ##########################################################
    // console side, one frame of bus words
    // ##########################################################
    task automatic send_frame(input int frame);
        int          line_n;
        int          col_n;
        logic [23:0] p;
        repeat (VSYNC_PULSE) drive_bus(1'b1, 1'b0, 12'h000);
        for (line_n = 0; line_n < `DCX_FRAME_HEIGHT; line_n++) begin
            repeat (HSYNC_LOW) drive_bus(1'b0, 1'b1, 12'h000);
            for (col_n = 0; col_n < `DCX_FRAME_WIDTH; col_n++) begin
                p = patterns[frame * FRAME_PIXELS + line_n * `DCX_FRAME_WIDTH + col_n];
                drive_bus(1'b1, 1'b1, first_word(p));
                drive_bus(1'b1, 1'b1, second_word(p));
            end
            repeat (LINE_BLANK) drive_bus(1'b1, 1'b1, 12'h000);
        end
    endtask

    // a pixel may change between frames only where its pattern changed
    task automatic check_rewrite();
        int   i;
        logic pattern_changed;
        logic output_changed;
        for (i = 0; i < FRAME_PIXELS; i++) begin
            pattern_changed = patterns[i] != patterns[FRAME_PIXELS + i];
            output_changed  = captured[i] !== captured[FRAME_PIXELS + i];
            check_value("VIDEO change", 32'(pattern_changed), 32'(output_changed));
        end
    endtask

    task automatic check_column();
        int          line_n;
        int          col_n;
        int          index;
        logic        exp_de;
        logic [23:0] exp_video;
        line_n    = position / `DCX_H_TOTAL;
        col_n     = position % `DCX_H_TOTAL;
        exp_de    = (col_n < `DCX_FRAME_WIDTH) && (line_n < `DCX_FRAME_HEIGHT);
        index     = frames_done * FRAME_PIXELS + line_n * `DCX_FRAME_WIDTH + col_n;
        exp_video = 24'd0;
        if (exp_de) begin
            exp_video       = patterns[index];
            captured[index] = video;
        end
        check_value("DE", 32'(exp_de), 32'(de));
        check_value("HSYNC", 32'(col_n < `DCX_H_TOTAL - `DCX_H_SYNC), 32'(hsync));
        check_value("VSYNC", 32'(line_n < `DCX_V_TOTAL - `DCX_V_SYNC), 32'(vsync));
        check_value("VIDEO", 32'(exp_video), 32'(video));
        de_cycles        += (de === 1'b1) ? 1 : 0;
        hsync_low_cycles += (hsync === 1'b0) ? 1 : 0;
        vsync_low_cycles += (vsync === 1'b0) ? 1 : 0;
        position++;
        if (position == OUTPUT_FRAME_CYCLES) begin
            check_value("DE cycles", FRAME_PIXELS, de_cycles);
            check_value("HSYNC low cycles", `DCX_H_SYNC * `DCX_V_TOTAL, hsync_low_cycles);
            check_value("VSYNC low cycles", `DCX_V_SYNC * `DCX_H_TOTAL, vsync_low_cycles);
            finish_test($sformatf("output frame %0d", frames_done));
            if (frames_done == FRAME_COUNT - 1) begin
                check_rewrite();
                finish_test("second frame rewrites the buffer");
            end
            frames_done++;
            in_frame = 1'b0;
        end
    endtask

    // ##########################################################
    // output monitor, sampled away from the hdmi_clock rising edge
    // ##########################################################
    always @(negedge hdmi_clock) begin
        if (cycle_count > 0) begin
            if (!in_frame && de === 1'b1 && frames_done < FRAME_COUNT) begin
                if (frames_done == 0) begin
                    finish_test("idle outputs before the first frame");
                end
                in_frame         = 1'b1;   // every output frame opens on an active column
                position         = 0;
                de_cycles        = 0;
                hsync_low_cycles = 0;
                vsync_low_cycles = 0;
            end
            if (in_frame) begin
                check_column();
            end else begin
                check_value("DE", 32'd0, 32'(de));
                check_value("HSYNC", 32'd1, 32'(hsync));
                check_value("VSYNC", 32'd1, 32'(vsync));
                check_value("VIDEO", 32'd0, 32'(video));
            end
        end
    end

    always @(posedge clock54) begin
        cycle_count++;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: output frames did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        arst_n = 1'b0;
        _hsync = 1'b1;
        _vsync = 1'b1;
        data   = 12'h000;
        $readmemh("test/video_patterns.txt", patterns);
        repeat (4) @(posedge clock54);
        @(negedge clock54);
        arst_n = 1'b1;
        repeat (4) @(posedge clock54);
        for (int frame = 0; frame < FRAME_COUNT; frame++) begin
            send_frame(frame);
            wait (frames_done == frame + 1);   // buffer is free once the raster is out
        end
        repeat (8) @(posedge clock54);
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- test/video_patterns.txt
// 24-bit RGB pixels, red in the top byte, four per row
// frame 0 in the first eight rows, frame 1 in the last eight
102030 4050a0 ff0000 00ff00
0000ff ffffff 000000 123456
789abc def012 a5a5a5 5a5a5a
0f1e2d 3c4b5a 696867 f0e1d2
111111 222222 333333 444444
555555 666666 777777 888888
c0ffee 0ddba1 badc0d e1f2a3
b4c5d6 e7f809 1a2b3c 4d5e6f
102030 4050a0 00ffff 00ff00
0000ff ffffff 000000 123456
789abc def012 a5a5a5 5a5a5a
0f1e2d 3c4b5a 696867 f0e1d2
111111 2222aa 333333 444444
555555 666666 77bb77 888888
c0ffee 0ddba1 badc0d e1f2a3
b4c5d6 e7f809 1a2b3c 4d5e60
